//--- hdl/synth_pkg.sv
package synth_pkg;

  // --------------------------------------------------
  // data widths
  // --------------------------------------------------
  typedef logic [7:0]  scan_t;    // raw ps/2 scan code
  typedef logic [7:0]  key_t;     // ascii letter
  typedef logic [4:0]  note_t;    // 0-6 low, 7-13 mid, 14-20 high
  typedef logic [3:0]  volume_t;  // 0 .. VOLUME_MAX
  typedef logic [11:0] period_t;  // tone period in ticks

  typedef enum logic [1:0] {
    MODE_HOME,
    MODE_PIANO,
    MODE_VOLUME
  } mode_t;

  typedef logic menu_item_t;      // 0 piano, 1 volume

  // --------------------------------------------------
  // ps/2 framing
  // --------------------------------------------------
  localparam int    PS2_FRAME_BITS = 11;     // start, 8 data, parity, stop
  localparam scan_t SCAN_BREAK     = 8'hF0;  // release prefix

  // --------------------------------------------------
  // volume and tone timing
  // --------------------------------------------------
  localparam volume_t VOLUME_MAX    = 4'd8;  // full duty is 8/8
  localparam volume_t VOLUME_RESET  = 4'd4;  // half duty
  localparam int      TONE_TICK_DIV = 4;     // clocks per tick

  // Half-period divider values of the board design, rounded to a
  // multiple of 8 so that period * volume / 8 stays exact.
  localparam period_t NOTE_PERIOD [21] = '{
    12'd3816,  // low 1
    12'd3400,
    12'd3032,
    12'd2864,
    12'd2552,
    12'd2272,
    12'd2024,  // low 7
    12'd1912,  // mid 1
    12'd1704,
    12'd1520,
    12'd1432,
    12'd1280,
    12'd1136,
    12'd1016,  // mid 7
    12'd960,   // high 1
    12'd848,
    12'd760,
    12'd720,
    12'd640,
    12'd568,
    12'd504    // high 7
  };

  // --------------------------------------------------
  // menu keys
  // --------------------------------------------------
  localparam key_t KEY_UP         = 8'h57;  // W
  localparam key_t KEY_DOWN       = 8'h53;  // S
  localparam key_t KEY_ENTER      = 8'h44;  // D
  localparam key_t KEY_BACK_HOME  = 8'h41;  // A, leaves volume mode
  localparam key_t KEY_BACK_PIANO = 8'h59;  // Y, leaves piano mode

endpackage

//--- hdl/ps2_receiver.sv
module ps2_receiver (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ps2_clk,
  input  logic             ps2_data,
  output synth_pkg::scan_t scan_code,
  output logic             scan_valid
);

  logic       ps2_clk_s1;
  logic       ps2_clk_s2;
  logic       ps2_clk_d;   // edge register
  logic       ps2_fall;
  logic [3:0] bit_cnt;     // position inside the frame
  logic [7:0] shift;

  // --------------------------------------------------
  // ps2_clk synchronizer and falling edge
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ps2_clk_s1 <= 1'b1;  // bus idles high
      ps2_clk_s2 <= 1'b1;
      ps2_clk_d  <= 1'b1;
    end else begin
      ps2_clk_s1 <= ps2_clk;
      ps2_clk_s2 <= ps2_clk_s1;
      ps2_clk_d  <= ps2_clk_s2;
    end
  end

  assign ps2_fall = ps2_clk_d & ~ps2_clk_s2;

  // --------------------------------------------------
  // frame capture
  // --------------------------------------------------
  // The device holds ps2_data for half a bit around the falling edge,
  // so sampling it a few clocks late is still safe.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bit_cnt    <= '0;
      scan_valid <= 1'b0;
    end else begin
      scan_valid <= 1'b0;
      if (ps2_fall) begin
        if (int'(bit_cnt) == synth_pkg::PS2_FRAME_BITS - 1) begin
          bit_cnt    <= '0;  // stop bit, frame done
          scan_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ps2_fall && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      shift <= {ps2_data, shift[7:1]};  // lsb first
    end
    if (ps2_fall && int'(bit_cnt) == synth_pkg::PS2_FRAME_BITS - 1) begin
      scan_code <= shift;
    end
  end

  a_bit_cnt_range : assert property (@(posedge clk) disable iff (!rstn)
    int'(bit_cnt) < synth_pkg::PS2_FRAME_BITS);

endmodule

//--- hdl/key_decoder.sv
module key_decoder (
  input  logic             clk,
  input  logic             rstn,
  input  synth_pkg::scan_t scan_code,
  input  logic             scan_valid,
  output synth_pkg::key_t  key,
  output logic             key_held,
  output logic             key_press
);

  logic            break_flag;  // last code was F0
  synth_pkg::key_t ascii;

  // set 2 scan code to upper case ascii, 0 for anything else
  function automatic synth_pkg::key_t scan_to_ascii(input synth_pkg::scan_t code);
    case (code)
      8'h1C:   return 8'h41;  // A
      8'h32:   return 8'h42;  // B
      8'h21:   return 8'h43;  // C
      8'h23:   return 8'h44;  // D
      8'h24:   return 8'h45;  // E
      8'h2B:   return 8'h46;  // F
      8'h34:   return 8'h47;  // G
      8'h33:   return 8'h48;  // H
      8'h43:   return 8'h49;  // I
      8'h3B:   return 8'h4A;  // J
      8'h42:   return 8'h4B;  // K
      8'h4B:   return 8'h4C;  // L
      8'h3A:   return 8'h4D;  // M
      8'h31:   return 8'h4E;  // N
      8'h44:   return 8'h4F;  // O
      8'h4D:   return 8'h50;  // P
      8'h15:   return 8'h51;  // Q
      8'h2D:   return 8'h52;  // R
      8'h1B:   return 8'h53;  // S
      8'h2C:   return 8'h54;  // T
      8'h3C:   return 8'h55;  // U
      8'h2A:   return 8'h56;  // V
      8'h1D:   return 8'h57;  // W
      8'h22:   return 8'h58;  // X
      8'h35:   return 8'h59;  // Y
      8'h1A:   return 8'h5A;  // Z
      default: return 8'h00;
    endcase
  endfunction

  assign ascii = scan_to_ascii(scan_code);

  // --------------------------------------------------
  // make / break tracking
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      break_flag <= 1'b0;
      key        <= '0;
      key_held   <= 1'b0;
      key_press  <= 1'b0;
    end else begin
      key_press <= 1'b0;
      if (scan_valid) begin
        if (scan_code == synth_pkg::SCAN_BREAK) begin
          break_flag <= 1'b1;
        end else if (break_flag) begin
          break_flag <= 1'b0;
          if (ascii != 8'h00 && ascii == key) begin
            key_held <= 1'b0;  // only the held key releases
          end
        end else if (ascii != 8'h00) begin
          key       <= ascii;
          key_held  <= 1'b1;
          key_press <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/menu_controller.sv
module menu_controller (
  input  logic                  clk,
  input  logic                  rstn,
  input  synth_pkg::key_t       key,
  input  logic                  key_press,
  input  logic                  key_held,
  output synth_pkg::mode_t      mode,
  output synth_pkg::menu_item_t cursor,
  output synth_pkg::volume_t    volume,
  output synth_pkg::note_t      note,
  output logic                  note_on
);

  logic [5:0] note_map;  // {mapped, note}

  // keyboard layout: bottom row low, home row mid, top row high
  function automatic logic [5:0] key_to_note(input synth_pkg::key_t k);
    case (k)
      8'h5A:   return {1'b1, 5'd0};   // Z
      8'h58:   return {1'b1, 5'd1};   // X
      8'h43:   return {1'b1, 5'd2};   // C
      8'h56:   return {1'b1, 5'd3};   // V
      8'h42:   return {1'b1, 5'd4};   // B
      8'h4E:   return {1'b1, 5'd5};   // N
      8'h4D:   return {1'b1, 5'd6};   // M
      8'h41:   return {1'b1, 5'd7};   // A
      8'h53:   return {1'b1, 5'd8};   // S
      8'h44:   return {1'b1, 5'd9};   // D
      8'h46:   return {1'b1, 5'd10};  // F
      8'h4A:   return {1'b1, 5'd11};  // J
      8'h4B:   return {1'b1, 5'd12};  // K
      8'h4C:   return {1'b1, 5'd13};  // L
      8'h51:   return {1'b1, 5'd14};  // Q
      8'h57:   return {1'b1, 5'd15};  // W
      8'h45:   return {1'b1, 5'd16};  // E
      8'h52:   return {1'b1, 5'd17};  // R
      8'h49:   return {1'b1, 5'd18};  // I
      8'h4F:   return {1'b1, 5'd19};  // O
      8'h50:   return {1'b1, 5'd20};  // P
      default: return {1'b0, 5'd0};   // G, H, T, U, Y ... stay silent
    endcase
  endfunction

  assign note_map = key_to_note(key);
  assign note     = note_map[4:0];
  assign note_on  = key_held && note_map[5] && (mode == synth_pkg::MODE_PIANO);

  // --------------------------------------------------
  // mode FSM, cursor and volume register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mode   <= synth_pkg::MODE_HOME;
      cursor <= 1'b0;
      volume <= synth_pkg::VOLUME_RESET;
    end else if (key_press) begin
      case (mode)
        synth_pkg::MODE_HOME: begin
          if (key == synth_pkg::KEY_UP || key == synth_pkg::KEY_DOWN) begin
            cursor <= ~cursor;  // two items, either way wraps
          end else if (key == synth_pkg::KEY_ENTER) begin
            mode <= cursor ? synth_pkg::MODE_VOLUME : synth_pkg::MODE_PIANO;
          end
        end
        synth_pkg::MODE_VOLUME: begin
          if (key == synth_pkg::KEY_UP && volume != synth_pkg::VOLUME_MAX) begin
            volume <= volume + 1'b1;
          end else if (key == synth_pkg::KEY_DOWN && volume != '0) begin
            volume <= volume - 1'b1;
          end else if (key == synth_pkg::KEY_BACK_HOME) begin
            mode <= synth_pkg::MODE_HOME;
          end
        end
        synth_pkg::MODE_PIANO: begin
          if (key == synth_pkg::KEY_BACK_PIANO) begin
            mode <= synth_pkg::MODE_HOME;
          end
        end
        default: mode <= synth_pkg::MODE_HOME;
      endcase
    end
  end

  a_volume_max : assert property (@(posedge clk) disable iff (!rstn)
    volume <= synth_pkg::VOLUME_MAX);

endmodule

//--- hdl/tone_generator.sv
module tone_generator (
  input  logic               clk,
  input  logic               rstn,
  input  synth_pkg::note_t   note,
  input  logic               note_on,
  input  synth_pkg::volume_t volume,
  output logic               audio
);

  logic [$clog2(synth_pkg::TONE_TICK_DIV)-1:0] presc;
  logic [$clog2(synth_pkg::TONE_TICK_DIV)-1:0] presc_nxt;
  synth_pkg::period_t phase;
  synth_pkg::period_t phase_nxt;
  synth_pkg::period_t period;
  synth_pkg::note_t   note_q;
  logic               note_on_q;
  logic               tick;
  logic               restart;
  logic [12:0]        high_len;  // ticks of high level per period
  logic               audio_q;

  // --------------------------------------------------
  // period lookup and duty threshold
  // --------------------------------------------------
  assign period = (int'(note) < $size(synth_pkg::NOTE_PERIOD)) ?
                  synth_pkg::NOTE_PERIOD[note] : synth_pkg::NOTE_PERIOD[0];
  assign high_len = 13'(period >> 3) * 13'(volume);  // period is a multiple of 8

  assign tick    = int'(presc) == synth_pkg::TONE_TICK_DIV - 1;
  assign restart = note_on && (!note_on_q || note != note_q);  // new key

  always_comb begin
    presc_nxt = presc;
    phase_nxt = phase;
    if (restart) begin
      presc_nxt = '0;
      phase_nxt = '0;
    end else begin
      presc_nxt = tick ? '0 : presc + 1'b1;
      if (tick) begin
        phase_nxt = (phase >= period - 1'b1) ? '0 : phase + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      presc     <= '0;
      phase     <= '0;
      note_q    <= '0;
      note_on_q <= 1'b0;
      audio_q   <= 1'b0;
    end else begin
      presc     <= presc_nxt;
      phase     <= phase_nxt;
      note_q    <= note;
      note_on_q <= note_on;
      audio_q   <= note_on && (13'(phase_nxt) < high_len);  // aligned with phase
    end
  end

  assign audio = audio_q & note_on;  // cut at once on release

  a_quiet_when_off : assert property (@(posedge clk) disable iff (!rstn)
    !note_on |=> !audio_q);

  a_rise_on_key : assert property (@(posedge clk) disable iff (!rstn)
    $rose(note_on) && volume != '0 |=> audio || !note_on);

endmodule

//--- hdl/synth_top.sv
module synth_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  ps2_clk,
  input  logic                  ps2_data,
  output logic                  audio,
  output synth_pkg::mode_t      mode,
  output synth_pkg::menu_item_t cursor,
  output synth_pkg::volume_t    volume
);

  synth_pkg::scan_t scan_code;
  logic             scan_valid;
  synth_pkg::key_t  key;
  logic             key_press;
  logic             key_held;
  synth_pkg::note_t note;
  logic             note_on;

  // --------------------------------------------------
  // keyboard path
  // --------------------------------------------------
  ps2_receiver ps2_receiver_inst (
    .clk        (clk),
    .rstn       (rstn),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scan_code  (scan_code),
    .scan_valid (scan_valid)
  );

  key_decoder key_decoder_inst (
    .clk        (clk),
    .rstn       (rstn),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .key        (key),
    .key_held   (key_held),
    .key_press  (key_press)
  );

  // --------------------------------------------------
  // control and sound
  // --------------------------------------------------
  menu_controller menu_controller_inst (
    .clk       (clk),
    .rstn      (rstn),
    .key       (key),
    .key_press (key_press),
    .key_held  (key_held),
    .mode      (mode),    // board leds
    .cursor    (cursor),
    .volume    (volume),
    .note      (note),
    .note_on   (note_on)
  );

  tone_generator tone_generator_inst (
    .clk     (clk),
    .rstn    (rstn),
    .note    (note),
    .note_on (note_on),
    .volume  (volume),
    .audio   (audio)
  );

endmodule

//--- test/tb_synth.sv
module tb_synth;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_BUDGET = 200;                 // frames the tests send
  localparam int TONE_BUDGET  = 4 * 6 * 4 * 3816;    // four notes, six periods

  logic                  clk;
  logic                  rstn;
  logic                  ps2_clk;
  logic                  ps2_data;
  logic                  audio;
  synth_pkg::mode_t      mode;
  synth_pkg::menu_item_t cursor;
  synth_pkg::volume_t    volume;

  synth_pkg::mode_t      exp_mode;    // reference model
  logic                  exp_cursor;
  int                    exp_volume;
  logic                  check_en;
  int                    errors;
  int                    tests;
  int                    failed;
  int                    test_err0;
  int                    frames;

  // scan codes in note order, bottom row, home row, top row
  logic [7:0] note_scan [21] = '{
    8'h1A, 8'h22, 8'h21, 8'h2A, 8'h32, 8'h31, 8'h3A,
    8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h3B, 8'h42, 8'h4B,
    8'h15, 8'h1D, 8'h24, 8'h2D, 8'h43, 8'h44, 8'h4D
  };

  synth_top synth_top_inst (
    .clk      (clk),
    .rstn     (rstn),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .audio    (audio),
    .mode     (mode),
    .cursor   (cursor),
    .volume   (volume)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
    errors++;
  endtask

  task automatic begin_test();
    test_err0 = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: FAILED with %0d errors", name, errors - test_err0);
    end
  endtask

  // one PS/2 frame, 40 clocks per bit, odd parity
  task automatic send_frame(input logic [7:0] code);
    logic [10:0] bits;
    bits = {1'b1, ~^code, code, 1'b0};
    check_en = 1'b0;  // model is stale until the frame lands
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      ps2_data <= bits[i];
      repeat (19) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (20) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    repeat (8) @(posedge clk);
    frames++;
    @(negedge clk);  // model moves between clock edges
  endtask

  task automatic release_key(input logic [7:0] code);
    send_frame(8'hF0);
    send_frame(code);
  endtask

  task automatic tap_key(input logic [7:0] code);
    send_frame(code);
    release_key(code);
  endtask

  task automatic step_volume(input logic up);
    tap_key(up ? 8'h1D : 8'h1B);  // W or S
    if (up && exp_volume < 8) begin
      exp_volume++;
    end else if (!up && exp_volume > 0) begin
      exp_volume--;
    end
    check_en = 1'b1;
  endtask

  task automatic expect_silent(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      assert (!audio) else begin
        report_mismatch("audio", 1, 0);
        break;
      end
    end
  endtask

  // rises and falls of audio, three whole periods after the first rise
  task automatic measure_tone(input int n);
    int rises [4];
    int falls [4];
    int nr;
    int nf;
    int t;
    int exp_p;
    int exp_h;
    logic prev;
    nr = 0;
    nf = 0;
    t = 0;
    prev = audio;
    exp_p = synth_pkg::TONE_TICK_DIV * int'(synth_pkg::NOTE_PERIOD[n]);
    exp_h = exp_p * exp_volume / 8;
    while (nr < 4 && t < 6 * exp_p) begin
      @(posedge clk);
      t++;
      if (audio && !prev) begin
        rises[nr] = t;
        nr++;
      end else if (!audio && prev && nr > nf) begin
        falls[nf] = t;
        nf++;
      end
      prev = audio;
    end
    assert (nr == 4) else begin
      $display("note %0d gave no steady tone, %0d rising edges seen", n, nr);
      errors++;
    end
    if (nr == 4) begin
      for (int i = 0; i < 3; i++) begin
        assert (rises[i + 1] - rises[i] == exp_p)
          else report_mismatch("audio period", rises[i + 1] - rises[i], exp_p);
        assert (falls[i] - rises[i] == exp_h)
          else report_mismatch("audio high time", falls[i] - rises[i], exp_h);
      end
    end
  endtask

  // --------------------------------------------------
  // register checks against the model
  // --------------------------------------------------
  a_mode : assert property (@(posedge clk) disable iff (!rstn || !check_en)
    mode == exp_mode) else report_mismatch("mode", int'(mode), int'(exp_mode));

  a_cursor : assert property (@(posedge clk) disable iff (!rstn || !check_en)
    cursor == exp_cursor) else report_mismatch("cursor", int'(cursor), int'(exp_cursor));

  a_volume : assert property (@(posedge clk) disable iff (!rstn || !check_en)
    int'(volume) == exp_volume) else report_mismatch("volume", int'(volume), exp_volume);

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    int idx;
    void'($urandom(89));
    rstn       = 1'b0;
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    exp_mode   = synth_pkg::MODE_HOME;
    exp_cursor = 1'b0;
    exp_volume = 4;
    check_en   = 1'b0;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    frames     = 0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    begin_test();
    assert (!audio) else report_mismatch("audio", 1, 0);
    check_en = 1'b1;
    repeat (4) @(posedge clk);
    end_test("reset state");

    begin_test();
    tap_key(8'h1B);  // S
    exp_cursor = 1'b1;
    check_en = 1'b1;
    tap_key(8'h1D);  // W wraps back
    exp_cursor = 1'b0;
    check_en = 1'b1;
    tap_key(8'h1B);
    exp_cursor = 1'b1;
    check_en = 1'b1;
    tap_key(8'h23);  // D
    exp_mode = synth_pkg::MODE_VOLUME;
    check_en = 1'b1;
    tap_key(8'h1C);  // A
    exp_mode = synth_pkg::MODE_HOME;
    check_en = 1'b1;
    tap_key(8'h1D);
    exp_cursor = 1'b0;
    check_en = 1'b1;
    tap_key(8'h23);
    exp_mode = synth_pkg::MODE_PIANO;
    check_en = 1'b1;
    tap_key(8'h35);  // Y
    exp_mode = synth_pkg::MODE_HOME;
    check_en = 1'b1;
    end_test("menu navigation");

    begin_test();
    tap_key(8'h1B);
    exp_cursor = 1'b1;
    check_en = 1'b1;
    tap_key(8'h23);
    exp_mode = synth_pkg::MODE_VOLUME;
    check_en = 1'b1;
    repeat (6) step_volume(1'b1);   // into saturation at the top
    repeat (10) step_volume(1'b0);  // and at zero
    repeat (8) step_volume(1'($urandom % 2));
    while (exp_volume < 6) step_volume(1'b1);
    while (exp_volume > 6) step_volume(1'b0);
    end_test("volume control");

    begin_test();
    tap_key(8'h1C);
    exp_mode = synth_pkg::MODE_HOME;
    check_en = 1'b1;
    tap_key(8'h1D);
    exp_cursor = 1'b0;
    check_en = 1'b1;
    tap_key(8'h23);
    exp_mode = synth_pkg::MODE_PIANO;
    check_en = 1'b1;
    for (int k = 0; k < 3; k++) begin
      idx = int'($urandom % 21);
      send_frame(note_scan[idx]);
      check_en = 1'b1;
      measure_tone(idx);
      release_key(note_scan[idx]);
      check_en = 1'b1;
      expect_silent(200);
    end
    end_test("tone pitch and duty");

    begin_test();
    tap_key(8'h34);  // G has no note
    check_en = 1'b1;
    send_frame(8'h34);
    expect_silent(2000);
    release_key(8'h34);
    send_frame(8'h15);  // Q held
    release_key(8'h1A);  // Z released, not held
    check_en = 1'b1;
    measure_tone(14);
    release_key(8'h15);
    check_en = 1'b1;
    expect_silent(500);
    tap_key(8'h35);
    exp_mode = synth_pkg::MODE_HOME;
    check_en = 1'b1;
    repeat (4) @(posedge clk);
    end_test("break handling");

    $display("tests %0d, failed %0d, errors %0d, frames %0d", tests, failed, errors, frames);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin
    longint limit;
    limit = 2 * (longint'(FRAME_BUDGET) * 11 * 80 + longint'(TONE_BUDGET));
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d clocks, tests did not finish", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- ps2_synth.f
hdl/synth_pkg.sv
hdl/ps2_receiver.sv
hdl/key_decoder.sv
hdl/menu_controller.sv
hdl/tone_generator.sv
hdl/synth_top.sv
test/tb_synth.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_synth -f ps2_synth.f -o sim_synth

output=$(./obj_dir/sim_synth)
echo "$output"
echo "$output" | grep -q "^Verification passed$"
